/* hdl/regfile_defs.svh */
// Register file sizes

`ifndef REGFILE_DEFS_SVH
`define REGFILE_DEFS_SVH

// ##############################
// Storage geometry
// ##############################

// Width of one stored word
`define RF_DATA_W 64

// Word address width
`define RF_ADDR_W 3

`define RF_DEPTH  8           // Words in the array

`endif

/* hdl/regfile_pkg.sv */
// Register file types

`include "regfile_defs.svh"

package regfile_pkg;

    typedef logic [`RF_DATA_W-1:0] rf_data_t;
    typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

    // ##############################
    // Atomic engine FSM
    // ##############################
    typedef enum logic [1:0] {
        RMW_IDLE  = 2'd0,
        RMW_READ  = 2'd1,     // Word read, original captured
        RMW_WRITE = 2'd2      // Merged word written back
    } rmw_state_e;

    // Write request into the array
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
        rf_data_t data;
    } wr_req_t;

    // Read-modify-write command
    typedef struct packed {
        rf_addr_t addr;
        rf_data_t mask;       // Bits to clear
        rf_data_t value;      // Bits to set
    } rmw_cmd_t;

endpackage

/* hdl/reg_array.sv */
// Register storage array

`timescale 1ns/1ns

`include "regfile_defs.svh"

module reg_array (
    input  logic                 clk,
    input  logic                 rst_n,

    input  regfile_pkg::wr_req_t commit,

    input  regfile_pkg::rf_addr_t rd_addr_a,
    output regfile_pkg::rf_data_t rd_data_a,

    input  regfile_pkg::rf_addr_t rd_addr_b,
    output regfile_pkg::rf_data_t rd_data_b
);

    regfile_pkg::rf_data_t mem [`RF_DEPTH];

    // ##############################
    // Single write port
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem <= '{default: '0};               // Known contents after reset
        end else if (commit.valid) begin
            mem[commit.addr] <= commit.data;
        end
    end

    // ##############################
    // Read ports
    // ##############################

    // Both ports see the current contents, no bypass here
    always_comb begin
        rd_data_a = mem[rd_addr_a];              // Atomic engine side
    end

    always_comb begin
        rd_data_b = mem[rd_addr_b];              // Host side
    end

endmodule

/* hdl/rmw_engine.sv */
// Atomic read-modify-write engine

`timescale 1ns/1ns

`include "regfile_defs.svh"

module rmw_engine (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  start,
    input  regfile_pkg::rmw_cmd_t cmd,

    output regfile_pkg::rf_addr_t rd_addr,
    input  regfile_pkg::rf_data_t rd_data,

    output regfile_pkg::wr_req_t  rmw_wr,
    output regfile_pkg::rf_data_t original_val,
    output logic                  busy,
    output regfile_pkg::rf_addr_t lock_addr
);

    regfile_pkg::rmw_state_e state;
    regfile_pkg::rmw_state_e state_nxt;
    regfile_pkg::rmw_cmd_t   cmd_q;
    logic                    accept;

    assign accept = (state == regfile_pkg::RMW_IDLE) && start;

    // ##############################
    // FSM
    // ##############################
    always_comb begin
        state_nxt = state;
        unique case (state)
            regfile_pkg::RMW_IDLE: begin
                if (start) begin
                    state_nxt = regfile_pkg::RMW_READ;
                end
            end
            regfile_pkg::RMW_READ:  state_nxt = regfile_pkg::RMW_WRITE;
            regfile_pkg::RMW_WRITE: state_nxt = regfile_pkg::RMW_IDLE;
            default:                state_nxt = regfile_pkg::RMW_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= regfile_pkg::RMW_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Command held for the whole operation, inputs are free afterwards
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= cmd;
        end
    end

    // ##############################
    // Read and merge
    // ##############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            original_val <= '0;
        end else if (state == regfile_pkg::RMW_READ) begin
            original_val <= rd_data;             // Held until next operation
        end
    end

    assign rd_addr = cmd_q.addr;

    always_comb begin
        rmw_wr.valid = (state == regfile_pkg::RMW_WRITE);
        rmw_wr.addr  = cmd_q.addr;
        rmw_wr.data  = (original_val & ~cmd_q.mask) | cmd_q.value;
    end

    // Busy also serves as the lock level
    assign busy      = (state != regfile_pkg::RMW_IDLE);
    assign lock_addr = cmd_q.addr;

endmodule

/* hdl/host_port.sv */
// Host access port

`timescale 1ns/1ns

`include "regfile_defs.svh"

module host_port (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  rd_en,
    input  regfile_pkg::rf_addr_t rd_addr,

    input  logic                  wr_en,
    input  regfile_pkg::rf_addr_t wr_addr,
    input  regfile_pkg::rf_data_t wr_data,

    output regfile_pkg::rf_addr_t array_rd_addr,
    input  regfile_pkg::rf_data_t array_rd_data,

    input  regfile_pkg::wr_req_t  commit,
    output regfile_pkg::wr_req_t  host_wr,
    output regfile_pkg::rf_data_t rd_data
);

    logic                  fwd_hit;
    regfile_pkg::rf_data_t rd_word;

    // ##############################
    // Write request
    // ##############################
    always_comb begin
        host_wr.valid = wr_en;
        host_wr.addr  = wr_addr;
        host_wr.data  = wr_data;
    end

    // ##############################
    // Registered read
    // ##############################
    assign array_rd_addr = rd_addr;

    // A write landing on the same edge wins over the array word
    assign fwd_hit = commit.valid && (commit.addr == rd_addr);
    assign rd_word = fwd_hit ? commit.data : array_rd_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= rd_word;                  // Held until next rd_en
        end
    end

endmodule

/* hdl/write_arbiter.sv */
// Array write arbiter

`timescale 1ns/1ns

`include "regfile_defs.svh"

module write_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,

    input  regfile_pkg::wr_req_t  rmw_wr,
    input  regfile_pkg::wr_req_t  host_wr,

    input  logic                  lock_active,
    input  regfile_pkg::rf_addr_t lock_addr,

    output regfile_pkg::wr_req_t  commit,
    output logic                  wr_dropped
);

    logic lock_hit;
    logic host_block;
    logic host_drop;

    // ##############################
    // Arbitration
    // ##############################
    assign lock_hit   = lock_active && (host_wr.addr == lock_addr);
    assign host_block = rmw_wr.valid || lock_hit;    // Engine first, then the lock
    assign host_drop  = host_wr.valid && host_block;

    always_comb begin
        commit = '0;
        if (rmw_wr.valid) begin
            commit = rmw_wr;
        end else if (host_wr.valid && !host_block) begin
            commit = host_wr;
        end
    end

    // ##############################
    // Drop flag
    // ##############################

    // One pulse per lost host write, no retry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_dropped <= 1'b0;
        end else begin
            wr_dropped <= host_drop;
        end
    end

endmodule

/* hdl/atomic_regfile_top.sv */
// Atomic register file top

`timescale 1ns/1ns

`include "regfile_defs.svh"

module atomic_regfile_top (
    input  logic                  clk,
    input  logic                  rst_n,

    // Atomic channel
    input  logic                  start,
    input  regfile_pkg::rf_addr_t addr,
    input  regfile_pkg::rf_data_t modify_mask,
    input  regfile_pkg::rf_data_t modify_val,
    output regfile_pkg::rf_data_t original_val,
    output logic                  busy,

    // Host channel
    input  logic                  rd_en,
    input  regfile_pkg::rf_addr_t rd_addr,
    output regfile_pkg::rf_data_t rd_data,
    input  logic                  wr_en,
    input  regfile_pkg::rf_addr_t wr_addr,
    input  regfile_pkg::rf_data_t wr_data,
    output logic                  wr_dropped
);

    regfile_pkg::rmw_cmd_t cmd;
    regfile_pkg::wr_req_t  rmw_wr;
    regfile_pkg::wr_req_t  host_wr;
    regfile_pkg::wr_req_t  commit;
    regfile_pkg::rf_addr_t rmw_rd_addr;
    regfile_pkg::rf_data_t rmw_rd_data;
    regfile_pkg::rf_addr_t host_rd_addr;
    regfile_pkg::rf_data_t host_rd_data;
    regfile_pkg::rf_addr_t lock_addr;
    logic                  lock_active;

    assign cmd         = '{addr: addr, mask: modify_mask, value: modify_val};
    assign lock_active = busy;                       // Lock spans the whole operation

    // ##############################
    // Blocks
    // ##############################
    reg_array reg_array_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .commit    (commit),
        .rd_addr_a (rmw_rd_addr),
        .rd_data_a (rmw_rd_data),
        .rd_addr_b (host_rd_addr),
        .rd_data_b (host_rd_data)
    );

    rmw_engine rmw_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .cmd          (cmd),
        .rd_addr      (rmw_rd_addr),
        .rd_data      (rmw_rd_data),
        .rmw_wr       (rmw_wr),
        .original_val (original_val),
        .busy         (busy),
        .lock_addr    (lock_addr)
    );

    host_port host_port_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .array_rd_addr (host_rd_addr),
        .array_rd_data (host_rd_data),
        .commit        (commit),
        .host_wr       (host_wr),
        .rd_data       (rd_data)
    );

    write_arbiter write_arbiter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rmw_wr      (rmw_wr),
        .host_wr     (host_wr),
        .lock_active (lock_active),
        .lock_addr   (lock_addr),
        .commit      (commit),
        .wr_dropped  (wr_dropped)
    );

endmodule

/* testbench/atomic_regfile_properties.sv */
// Atomic register file assertions

`timescale 1ns/1ns

module atomic_regfile_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  start,
    input logic                  busy,
    input logic                  wr_dropped,
    input regfile_pkg::rf_addr_t lock_addr,
    input regfile_pkg::wr_req_t  rmw_wr,
    input regfile_pkg::wr_req_t  host_wr,
    input regfile_pkg::wr_req_t  commit
);

    logic drop_cause;
    int   failures = 0;                         // Failed assertion count

    assign drop_cause = host_wr.valid &&
                        (rmw_wr.valid || (busy && (host_wr.addr == lock_addr)));

    // ##############################
    // Atomic window
    // ##############################
    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else begin
            $error("busy did not rise after an accepted start");
            failures++;
        end

    busy_second_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(busy) |=> busy)
        else begin
            $error("busy fell after one cycle");
            failures++;
        end

    busy_two_cycles: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && $past(busy)) |=> !busy)
        else begin
            $error("busy stayed high past two cycles");
            failures++;
        end

    // Only the engine may touch the locked word
    lock_owner: assert property (@(posedge clk) disable iff (!rst_n)
        (busy && commit.valid && (commit.addr == lock_addr)) |->
        (rmw_wr.valid && commit == rmw_wr))
        else begin
            $error("Locked word written by the host");
            failures++;
        end

    drop_has_cause: assert property (@(posedge clk) disable iff (!rst_n)
        wr_dropped |-> $past(drop_cause))
        else begin
            $error("wr_dropped without a dropped write");
            failures++;
        end

endmodule

bind atomic_regfile_top atomic_regfile_properties atomic_regfile_properties_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .busy       (busy),
    .wr_dropped (wr_dropped),
    .lock_addr  (lock_addr),
    .rmw_wr     (rmw_wr),
    .host_wr    (host_wr),
    .commit     (commit)
);

/* testbench/atomic_regfile_tb.sv */
// Atomic register file testbench

`timescale 1ns/1ns

`include "regfile_defs.svh"

module atomic_regfile_tb;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_FIELDS = 9;              // op addr data mask addr2 data2 orig rd drop
    localparam int MAX_CASES  = 64;

    localparam logic [63:0] OP_READ        = 64'd0;
    localparam logic [63:0] OP_WRITE       = 64'd1;
    localparam logic [63:0] OP_WRRD        = 64'd2;
    localparam logic [63:0] OP_RMW         = 64'd3;
    localparam logic [63:0] OP_RMW_WR_RD   = 64'd4;
    localparam logic [63:0] OP_RMW_WR_WR   = 64'd5;
    localparam logic [63:0] OP_RMW_RESTART = 64'd6;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    regfile_pkg::rf_addr_t addr;
    regfile_pkg::rf_data_t modify_mask;
    regfile_pkg::rf_data_t modify_val;
    regfile_pkg::rf_data_t original_val;
    logic                  busy;
    logic                  rd_en;
    regfile_pkg::rf_addr_t rd_addr;
    regfile_pkg::rf_data_t rd_data;
    logic                  wr_en;
    regfile_pkg::rf_addr_t wr_addr;
    regfile_pkg::rf_data_t wr_data;
    logic                  wr_dropped;

    logic [63:0]           case_mem [NUM_FIELDS*MAX_CASES];
    regfile_pkg::rf_data_t shadow [`RF_DEPTH];  // Model of the array
    int                    num_cases;
    logic                  cases_loaded = 1'b0;
    int                    dut_errors;
    int                    case_errors;

    atomic_regfile_top atomic_regfile_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the case count
    initial begin
        wait (cases_loaded);
        #(CLK_PERIOD * (num_cases * 10 + 20));
        $display("Timeout: the run did not finish within %0d cycles", num_cases * 10 + 20);
        $display("Errors found");
        $finish;
    end

    function automatic logic [63:0] case_field(input int c, input int f);
        return case_mem[c * NUM_FIELDS + f];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;                                    // Inputs change after the edge
    endtask

    task automatic check_dut(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s = %h, expected %h", $time, what, got, exp);
            dut_errors++;
        end
    endtask

    // Case file value checked against the model before the DUT check
    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp, input logic [63:0] model);
        assert (exp === model) else begin
            $display("[ERROR] %0t: case file gives %s = %h, model gives %h",
                     $time, what, exp, model);
            case_errors++;
        end
        check_dut(what, got, exp);
    endtask

    task automatic host_access(input logic wr, input logic rd, input regfile_pkg::rf_addr_t a,
                               input regfile_pkg::rf_data_t d, input logic [63:0] exp_rd,
                               input logic [63:0] exp_drop);
        wr_en   = wr;
        wr_addr = a;
        wr_data = d;
        rd_en   = rd;
        rd_addr = a;
        next_cycle();
        wr_en = 1'b0;
        rd_en = 1'b0;
        if (wr) begin
            shadow[a] = d;                      // Nothing blocks while the engine is idle
        end
        if (rd) begin
            check_value("rd_data", rd_data, exp_rd, shadow[a]);
        end
        check_value("wr_dropped", 64'(wr_dropped), exp_drop, 64'd0);
        check_dut("busy", 64'(busy), 64'd0);
    endtask

    task automatic rmw_access(input logic [63:0] op, input regfile_pkg::rf_addr_t a,
                              input regfile_pkg::rf_data_t val, input regfile_pkg::rf_data_t mask,
                              input regfile_pkg::rf_addr_t a2, input regfile_pkg::rf_data_t d2,
                              input logic [63:0] exp_orig, input logic [63:0] exp_drop);
        regfile_pkg::rf_data_t m_orig;
        logic [63:0]           m_drop;
        m_orig = shadow[a];
        m_drop = 64'((op == OP_RMW_WR_RD && a2 == a) || op == OP_RMW_WR_WR);
        start       = 1'b1;
        addr        = a;
        modify_mask = mask;
        modify_val  = val;
        next_cycle();                           // Edge k captures the command
        start       = 1'b0;
        addr        = ~a;                       // Engine must work from its own copy
        modify_mask = ~mask;
        modify_val  = ~val;
        check_dut("busy", 64'(busy), 64'd1);
        wr_en   = (op == OP_RMW_WR_RD);
        wr_addr = a2;
        wr_data = d2;
        if (op == OP_RMW_RESTART) begin
            start      = 1'b1;                  // Second start while busy
            addr       = a2;
            modify_val = d2;
        end
        next_cycle();                           // Edge k+1 reads the original
        start = 1'b0;
        check_value("original_val", original_val, exp_orig, m_orig);
        check_dut("busy", 64'(busy), 64'd1);
        if (op == OP_RMW_WR_RD) begin
            check_value("wr_dropped", 64'(wr_dropped), exp_drop, m_drop);
        end else begin
            check_dut("wr_dropped", 64'(wr_dropped), 64'd0);
        end
        if (op == OP_RMW_WR_RD && m_drop == 64'd0) begin
            shadow[a2] = d2;
        end
        wr_en = (op == OP_RMW_WR_WR);
        next_cycle();                           // Edge k+2 writes the merged word
        wr_en     = 1'b0;
        shadow[a] = (m_orig & ~mask) | val;
        check_dut("busy", 64'(busy), 64'd0);
        check_dut("original_val", original_val, exp_orig);
        if (op == OP_RMW_WR_RD) begin
            check_dut("wr_dropped", 64'(wr_dropped), 64'd0);
        end else begin
            check_value("wr_dropped", 64'(wr_dropped), exp_drop, m_drop);
        end
    endtask

    // ##############################
    // Main sequence
    // ##############################
    initial begin
        logic [63:0]           op;
        regfile_pkg::rf_addr_t a;
        regfile_pkg::rf_addr_t a2;
        int                    prop_failures;
        rst_n       = 1'b0;
        start       = 1'b0;
        addr        = '0;
        modify_mask = '0;
        modify_val  = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        dut_errors  = 0;
        case_errors = 0;
        for (int i = 0; i < NUM_FIELDS * MAX_CASES; i++) begin
            case_mem[i] = '1;                   // Unfilled entries end the list
        end
        $readmemh("testbench/atomic_regfile_cases.txt", case_mem);
        num_cases = 0;
        while (num_cases < MAX_CASES && case_field(num_cases, 0) != '1) begin
            num_cases++;
        end
        cases_loaded = 1'b1;
        for (int i = 0; i < `RF_DEPTH; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;
        if (num_cases == 0) begin
            $display("No test cases were read from the case file");
            case_errors++;
        end
        for (int c = 0; c < num_cases; c++) begin
            op = case_field(c, 0);
            a  = regfile_pkg::rf_addr_t'(case_field(c, 1));
            a2 = regfile_pkg::rf_addr_t'(case_field(c, 4));
            if (op <= OP_WRRD) begin
                host_access(op != OP_READ, op != OP_WRITE, a, case_field(c, 2),
                            case_field(c, 7), case_field(c, 8));
            end else if (op <= OP_RMW_RESTART) begin
                rmw_access(op, a, case_field(c, 2), case_field(c, 3), a2, case_field(c, 5),
                           case_field(c, 6), case_field(c, 8));
            end else begin
                $display("Case %0d has an unknown operation code %0h", c, op);
                case_errors++;
            end
        end
        prop_failures = atomic_regfile_top_i.atomic_regfile_properties_i.failures;
        $display("DUT errors: %0d, case file errors: %0d, property failures: %0d",
                 dut_errors, case_errors, prop_failures);
        if (dut_errors == 0 && case_errors == 0 && prop_failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* testbench/atomic_regfile_cases.txt */
// op addr data mask addr2 data2 exp_orig exp_rd exp_drop (hex)
// op: 0 read, 1 write, 2 write+read, 3 rmw, 4 rmw+write in read cycle, 5 rmw+write in write cycle, 6 rmw+second start
0 0 0 0 0 0 0 0 0
0 1 0 0 0 0 0 0 0
0 2 0 0 0 0 0 0 0
0 3 0 0 0 0 0 0 0
0 4 0 0 0 0 0 0 0
0 5 0 0 0 0 0 0 0
0 6 0 0 0 0 0 0 0
0 7 0 0 0 0 0 0 0
1 0 0123456789abcdef 0 0 0 0 0 0
1 3 ffffffffffffffff 0 0 0 0 0 0
1 5 deadbeef 0 0 0 0 0 0
0 0 0 0 0 0 0 0123456789abcdef 0
0 3 0 0 0 0 0 ffffffffffffffff 0
2 5 cafef00d12345678 0 0 0 0 cafef00d12345678 0
0 5 0 0 0 0 0 cafef00d12345678 0
3 0 12340000 ffff0000 0 0 0123456789abcdef 0 0
0 0 0 0 0 0 0 012345671234cdef 0
3 3 10 f0f0f0f0f0f0f0f0 0 0 ffffffffffffffff 0 0
0 3 0 0 0 0 0 0f0f0f0f0f0f0f1f 0
3 7 8000000000000001 0 0 0 0 0 0
0 7 0 0 0 0 0 8000000000000001 0
6 2 ff ffffffffffffffff 6 5555 0 0 0
0 2 0 0 0 0 0 ff 0
0 6 0 0 0 0 0 0 0
4 5 1 ff 5 1111 cafef00d12345678 0 1
0 5 0 0 0 0 0 cafef00d12345601 0
4 1 a0 0 4 4444444444444444 0 0 0
0 4 0 0 0 0 0 4444444444444444 0
0 1 0 0 0 0 0 a0 0
5 6 6 0 0 dddd 0 0 1
0 0 0 0 0 0 0 012345671234cdef 0
0 6 0 0 0 0 0 6 0

/* verilog.f */
+incdir+hdl
hdl/regfile_pkg.sv
hdl/reg_array.sv
hdl/rmw_engine.sv
hdl/host_port.sv
hdl/write_arbiter.sv
hdl/atomic_regfile_top.sv
testbench/atomic_regfile_properties.sv
testbench/atomic_regfile_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module atomic_regfile_tb \
    -f verilog.f \
    -o sim_atomic_regfile

out=$(./obj_dir/sim_atomic_regfile || true)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
